// File: verif/memmap_testdata.txt
// @000: byte count, operation count. @010: 16 header bytes, then ROM image bytes
// @100: one operation per line: opcode slot address wdata expected
// Opcodes 1 read, 2 work RAM write, 3 read from stored word, 4 gfx line then snd line together
// Slots 0 work RAM, 1 program ROM, 2 graphics, 3 sound; wdata bits 17:16 are the byte mask
@000
80 0e
@010
02 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00
5a 5b 58 59 5e 5f 5c 5d 52 53 50 51 56 57 54 55
4a 4b 48 49 4e 4f 4c 4d 42 43 40 41 46 47 44 45
7a 7b 78 79 7e 7f 7c 7d 72 73 70 71 76 77 74 75
6a 6b 68 69 6e 6f 6c 6d 62 63 60 61 66 67 64 65
1a 1b 18 19 1e 1f 1c 1d 12 13 10 11 16 17 14 15
0a 0b 08 09 0e 0f 0c 0d 02 03 00 01 06 07 04 05
3a 3b 38 39 3e 3f 3c 3d 32 33 30 31 36 37 34 35
@100
1 1 0003 00000 5d5c
1 1 0012 00000 7f7e
3 1 0012 00000 7f7e
1 2 0005 00000 1110
1 2 000e 00000 0706
1 3 0001 00000 3938
1 3 0006 00000 3736
3 3 0006 00000 3736
2 0 0004 01234 1234
2 0 0004 2abcd 12cd
1 0 0004 00000 12cd
3 0 0004 00000 12cd
4 2 0009 00000 0908
4 3 0004 00000 3332

// File: vlog.f
+incdir+logic
logic/memmap_pkg.sv
logic/rom_loader.sv
logic/bank_slots.sv
logic/memmap_top.sv
verif/sdram_model.sv
verif/memmap_tb.sv

// File: Bender.yml
package:
  name: memmap

sources:
  - include_dirs:
      - logic
    files:
      - logic/memmap_pkg.sv
      - logic/rom_loader.sv
      - logic/bank_slots.sv
      - logic/memmap_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/sdram_model.sv
      - verif/memmap_tb.sv

// File: verif/memmap_tb.sv
// Reads verif/memmap_testdata.txt relative to the run directory, so run from the project root
`timescale 1ns/1ns
`include "memmap_consts.svh"

module memmap_tb;

    typedef enum logic [3:0] {
        OP_READ   = 4'h1,
        OP_WRITE  = 4'h2,   // Work RAM only
        OP_CACHED = 4'h3,   // Must be served from the stored word
        OP_PAIR   = 4'h4    // Graphics and sound together on two lines
    } op_e;

    logic                   clk;
    logic                   reset;
    logic                   downloading;
    logic [`IOCTL_AW-1:0]   ioctl_addr;
    logic [7:0]             ioctl_dout;
    logic                   ioctl_wr;
    logic [1:0]             game_id;
    logic                   dec_en;
    logic                   ram_cs;
    logic [`SLOT_AW-1:0]    ram_addr;
    logic                   ram_rnw;
    logic [15:0]            ram_din;
    logic [1:0]             ram_dsn;
    logic [15:0]            ram_data;
    logic                   ram_ok;
    logic                   rom_cs;
    logic [`SLOT_AW-1:0]    rom_addr;
    logic [15:0]            rom_data;
    logic                   rom_ok;
    logic                   gfx_cs;
    logic [`SLOT_AW-1:0]    gfx_addr;
    logic [15:0]            gfx_data;
    logic                   gfx_ok;
    logic                   snd_cs;
    logic [`SLOT_AW-1:0]    snd_addr;
    logic [15:0]            snd_data;
    logic                   snd_ok;
    memmap_pkg::sdram_req_t ba0_req;
    memmap_pkg::sdram_req_t ba1_req;
    memmap_pkg::sdram_rsp_t ba0_rsp;
    memmap_pkg::sdram_rsp_t ba1_rsp;
    logic [15:0]            data_read;
    memmap_pkg::prog_req_t  prog;
    logic                   prog_ack;
    logic                   dwnld_busy;

    logic [31:0] tdata [0:511];
    int          errors       = 0;
    int          errs_start   = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          req_count    = 0;   // Bank strobes seen rising
    logic [1:0]  strobe_q     = 2'b00;
    int          cycles       = 0;
    int          limit        = 0;

    memmap_top DUT (.*);

    sdram_model u_sdram (.*);

    always #5 clk = ~clk;

    // Rising bank strobes counted on the falling edge
    always @(negedge clk) begin
        if ((ba0_req.rd || ba0_req.wr) && !strobe_q[0]) req_count++;
        if ((ba1_req.rd || ba1_req.wr) && !strobe_q[1]) req_count++;
        strobe_q = {ba1_req.rd || ba1_req.wr, ba0_req.rd || ba0_req.wr};
    end

    function automatic string state_name(input memmap_pkg::slot_state_e s);
        return s.name();
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: no result within %0d cycles, bank 0 slots %s %s, bank 1 slots %s %s",
                     limit, state_name(DUT.u_bank0.st[0]), state_name(DUT.u_bank0.st[1]),
                     state_name(DUT.u_bank1.st[0]), state_name(DUT.u_bank1.st[1]));
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errs_start) tests_failed++;
        $display("%0t ns test %0d %s: %s", $time, tests_run, name,
                 errors == errs_start ? "ok" : "mismatch");
    endtask

    task automatic drive_slot(input int slot, input logic cs, input logic [`SLOT_AW-1:0] addr);
        case (slot)
            0: begin
                ram_cs   = cs;
                ram_addr = addr;
            end
            1: begin
                rom_cs   = cs;
                rom_addr = addr;
            end
            2: begin
                gfx_cs   = cs;
                gfx_addr = addr;
            end
            default: begin
                snd_cs   = cs;
                snd_addr = addr;
            end
        endcase
    endtask

    function automatic logic slot_ok(input int slot);
        case (slot)
            0:       return ram_ok;
            1:       return rom_ok;
            2:       return gfx_ok;
            default: return snd_ok;
        endcase
    endfunction

    function automatic logic [15:0] slot_data(input int slot);
        case (slot)
            0:       return ram_data;
            1:       return rom_data;
            2:       return gfx_data;
            default: return snd_data;
        endcase
    endfunction

    task automatic load_byte(input int idx, input logic [7:0] value);
        ioctl_addr = idx[`IOCTL_AW-1:0];
        ioctl_dout = value;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        repeat (7) next_cycle();   // Strobes at least 8 cycles apart
        while (prog.we) next_cycle();
    endtask

    // One slot access with lat counting the cycles from cs to ok
    task automatic run_access(input int slot, input logic [`SLOT_AW-1:0] addr, input logic rnw,
                              input logic [15:0] din, input logic [1:0] dsn,
                              output int lat, output logic [15:0] data);
        drive_slot(slot, 1'b1, addr);
        ram_rnw = rnw;
        ram_din = din;
        ram_dsn = dsn;
        lat     = 0;
        do begin
            next_cycle();
            lat++;
        end while (!slot_ok(slot));
        data = slot_data(slot);
        drive_slot(slot, 1'b0, addr);
        ram_rnw = 1'b1;
        next_cycle();
        next_cycle();
    endtask

    initial begin
        int                  nbytes;
        int                  nops;
        int                  k;
        int                  base;
        int                  slot;
        int                  lat;
        int                  nreq;
        int                  at0;
        int                  at1;
        int                  n;
        op_e                 op;
        logic [`SLOT_AW-1:0] addr;
        logic [`SLOT_AW-1:0] addr2;
        logic [31:0]         wdat;
        logic [15:0]         expv;
        logic [15:0]         exp2;
        logic [15:0]         got;
        logic [21:0]         word_addr;
        string               name;

        clk         = 1'b0;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        ram_cs      = 1'b0;
        ram_addr    = '0;
        ram_rnw     = 1'b1;
        ram_din     = '0;
        ram_dsn     = 2'b11;
        rom_cs      = 1'b0;
        rom_addr    = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        $readmemh("verif/memmap_testdata.txt", tdata);
        nbytes = int'(tdata[0]);
        nops   = int'(tdata[1]);
        limit  = 40 * nbytes + 60 * nops;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Header and image bytes start at entry 16
        errs_start  = errors;
        downloading = 1'b1;
        for (k = 0; k < nbytes; k++) begin
            load_byte(k, tdata[16 + k][7:0]);
        end
        check_value("dwnld_busy while downloading", dwnld_busy, 1);
        downloading = 1'b0;   // Last write already acked
        next_cycle();
        check_value("game_id", game_id, tdata[17][1:0]);
        check_value("dec_en", dec_en, |tdata[16][1:0]);
        check_value("dwnld_busy", dwnld_busy, 0);
        finish_test("download");

        k = 0;
        while (k < nops) begin
            base       = 'h100 + 5 * k;
            op         = op_e'(tdata[base][3:0]);
            slot       = int'(tdata[base + 1]);
            addr       = tdata[base + 2][`SLOT_AW-1:0];
            wdat       = tdata[base + 3];
            expv       = tdata[base + 4][15:0];
            name       = $sformatf("%s slot %0d addr %h", op.name(), slot, addr);
            errs_start = errors;
            case (op)
                OP_READ, OP_CACHED: begin
                    nreq = req_count;
                    run_access(slot, addr, 1'b1, 16'h0000, 2'b11, lat, got);
                    check_value("read data", got, expv);
                    if (op == OP_CACHED) begin
                        check_value("bank requests", req_count, nreq);
                        check_value("hit latency", lat, 1);
                    end
                    k++;
                end
                OP_WRITE: begin
                    run_access(0, addr, 1'b0, wdat[15:0], wdat[17:16], lat, got);
                    word_addr = `RAM_OFFSET + 22'(addr);
                    check_value("model word", u_sdram.mem[0][word_addr[9:0]], expv);
                    k++;
                end
                OP_PAIR: begin
                    addr2 = tdata[base + 7][`SLOT_AW-1:0];
                    exp2  = tdata[base + 9][15:0];
                    drive_slot(2, 1'b1, addr);
                    drive_slot(3, 1'b1, addr2);
                    at0 = 0;
                    at1 = 0;
                    n   = 0;
                    while (at0 == 0 || at1 == 0) begin
                        next_cycle();
                        n++;
                        if (at0 == 0 && gfx_ok) at0 = n;
                        if (at1 == 0 && snd_ok) at1 = n;
                    end
                    check_value("gfx data", gfx_data, expv);
                    check_value("snd data", snd_data, exp2);
                    check_value("gfx ok first", at0 < at1, 1);
                    drive_slot(2, 1'b0, addr);
                    drive_slot(3, 1'b0, addr2);
                    next_cycle();
                    next_cycle();
                    k += 2;
                end
                default: begin
                    errors++;
                    $display("Unknown opcode %h on operation line %0d", tdata[base], k);
                    k++;
                end
            endcase
            finish_test(name);
        end

        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verif/sdram_model.sv
// Only banks 0 and 1 have request ports; 1K words per bank, address bits above 9 are ignored
`timescale 1ns/1ns

module sdram_model #(
    parameter int RD_LAT = 2                  // Cycles from ack to data-ready
) (
    input  logic                   clk,
    input  logic                   reset,
    input  memmap_pkg::sdram_req_t ba0_req,
    input  memmap_pkg::sdram_req_t ba1_req,
    output memmap_pkg::sdram_rsp_t ba0_rsp,
    output memmap_pkg::sdram_rsp_t ba1_rsp,
    output logic [15:0]            data_read,
    input  memmap_pkg::prog_req_t  prog,
    output logic                   prog_ack
);

    logic [15:0]            mem [4][1024];
    memmap_pkg::sdram_req_t req [2];
    memmap_pkg::sdram_rsp_t rsp [2];
    int                     phase [2];        // 0 idle, 1 ack delay, 2 read latency, 3 write done
    int                     cnt [2];
    logic [15:0]            rword [2];        // Word fetched at ack
    logic [31:0]            rand_state;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Active low byte mask
    function automatic logic [15:0] apply_mask(input logic [15:0] old, input logic [15:0] din,
                                               input logic [1:0] dsn);
        return {dsn[1] ? old[15:8] : din[15:8], dsn[0] ? old[7:0] : din[7:0]};
    endfunction

    assign req[0]  = ba0_req;
    assign req[1]  = ba1_req;
    assign ba0_rsp = rsp[0];
    assign ba1_rsp = rsp[1];

    always @(posedge clk) begin
        if (reset) begin
            rsp[0]     <= '0;
            rsp[1]     <= '0;
            phase[0]   <= 0;
            phase[1]   <= 0;
            prog_ack   <= 1'b0;
            rand_state <= 32'd46437;
        end else begin
            prog_ack <= prog.we && !prog_ack;   // One ack per held strobe
            if (prog.we && !prog_ack) begin
                mem[prog.ba][prog.addr[9:0]] <=
                    apply_mask(mem[prog.ba][prog.addr[9:0]], prog.data, prog.mask);
            end
            for (int b = 0; b < 2; b++) begin
                rsp[b] <= '0;
                case (phase[b])
                    0: if (req[b].rd || req[b].wr) begin
                        cnt[b]     <= int'(rand_state[17:16]);   // Ack delay 0 to 3
                        rand_state <= next_rand(rand_state);
                        phase[b]   <= 1;
                    end
                    1: if (cnt[b] == 0) begin
                        rsp[b].ack <= 1'b1;
                        rword[b]   <= mem[b][req[b].addr[9:0]];
                        if (req[b].wr) begin
                            mem[b][req[b].addr[9:0]] <=
                                apply_mask(mem[b][req[b].addr[9:0]], req[b].din, req[b].mask);
                        end
                        cnt[b]   <= RD_LAT;
                        phase[b] <= req[b].rd ? 2 : 3;
                    end else begin
                        cnt[b] <= cnt[b] - 1;
                    end
                    2: begin
                        rsp[b].dst <= cnt[b] == 1;
                        if (cnt[b] == 0) begin
                            rsp[b].rdy <= 1'b1;
                            data_read  <= rword[b];
                            phase[b]   <= 0;
                        end
                        cnt[b] <= cnt[b] - 1;
                    end
                    default: phase[b] <= 0;   // Bank drops its strobe during this cycle
                endcase
            end
        end
    end

endmodule

// File: logic/memmap_top.sv
// Banks 0 and 1 only; no decryption or video gating, the SDRAM controller sits outside
`timescale 1ns/1ns
`include "memmap_consts.svh"

module memmap_top (
    input  logic                   clk,
    input  logic                   reset,

    // ROM download
    input  logic                   downloading,
    input  logic [`IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]             ioctl_dout,
    input  logic                   ioctl_wr,

    // Header results
    output logic [1:0]             game_id,
    output logic                   dec_en,

    // Work RAM
    input  logic                   ram_cs,
    input  logic [`SLOT_AW-1:0]    ram_addr,
    input  logic                   ram_rnw,
    input  logic [15:0]            ram_din,
    input  logic [1:0]             ram_dsn,
    output logic [15:0]            ram_data,
    output logic                   ram_ok,

    // Program ROM
    input  logic                   rom_cs,
    input  logic [`SLOT_AW-1:0]    rom_addr,
    output logic [15:0]            rom_data,
    output logic                   rom_ok,

    // Graphics ROM
    input  logic                   gfx_cs,
    input  logic [`SLOT_AW-1:0]    gfx_addr,
    output logic [15:0]            gfx_data,
    output logic                   gfx_ok,

    // Sound ROM
    input  logic                   snd_cs,
    input  logic [`SLOT_AW-1:0]    snd_addr,
    output logic [15:0]            snd_data,
    output logic                   snd_ok,

    // SDRAM controller
    output memmap_pkg::sdram_req_t ba0_req,
    output memmap_pkg::sdram_req_t ba1_req,
    input  memmap_pkg::sdram_rsp_t ba0_rsp,
    input  memmap_pkg::sdram_rsp_t ba1_rsp,
    input  logic [15:0]            data_read,
    output memmap_pkg::prog_req_t  prog,
    input  logic                   prog_ack,
    output logic                   dwnld_busy
);

    logic [1:0] fd_en;

    rom_loader u_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_ack    ( prog_ack    ),
        .prog        ( prog        ),
        .game_id     ( game_id     ),
        .fd_en       ( fd_en       ),
        .dwnld_busy  ( dwnld_busy  )
    );

    // Either decoder enables decoding
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_en <= 1'b0;
        end else begin
            dec_en <= |fd_en;
        end
    end

    // Bank 0 with work RAM on the write slot
    bank_slots #(
        .SLOT0_WRITE ( 1'b1        ),
        .OFFSET0     ( `RAM_OFFSET ),
        .OFFSET1     ( 22'd0       )
    ) u_bank0 (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .hold       ( downloading ),
        .slot0_cs   ( ram_cs      ),
        .slot1_cs   ( rom_cs      ),
        .slot0_addr ( ram_addr    ),
        .slot1_addr ( rom_addr    ),
        .slot0_rnw  ( ram_rnw     ),
        .slot0_din  ( ram_din     ),
        .slot0_dsn  ( ram_dsn     ),
        .rsp        ( ba0_rsp     ),
        .data_read  ( data_read   ),
        .req        ( ba0_req     ),
        .slot0_dout ( ram_data    ),
        .slot1_dout ( rom_data    ),
        .slot0_ok   ( ram_ok      ),
        .slot1_ok   ( rom_ok      )
    );

    // Bank 1 is read only
    bank_slots #(
        .SLOT0_WRITE ( 1'b0        ),
        .OFFSET0     ( 22'd0       ),
        .OFFSET1     ( `SND_OFFSET )
    ) u_bank1 (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .hold       ( downloading ),
        .slot0_cs   ( gfx_cs      ),
        .slot1_cs   ( snd_cs      ),
        .slot0_addr ( gfx_addr    ),
        .slot1_addr ( snd_addr    ),
        .slot0_rnw  ( 1'b1        ),
        .slot0_din  ( 16'd0       ),
        .slot0_dsn  ( 2'b11       ),
        .rsp        ( ba1_rsp     ),
        .data_read  ( data_read   ),
        .req        ( ba1_req     ),
        .slot0_dout ( gfx_data    ),
        .slot1_dout ( snd_data    ),
        .slot0_ok   ( gfx_ok      ),
        .slot1_ok   ( snd_ok      )
    );

endmodule

// File: logic/bank_slots.sv
// Two slots on one SDRAM bank; slot 0 has priority, only slot 0 writes, one request in flight
`timescale 1ns/1ns
`include "memmap_consts.svh"

module bank_slots #(
    parameter bit          SLOT0_WRITE = 1'b0,
    parameter logic [21:0] OFFSET0     = 22'd0,
    parameter logic [21:0] OFFSET1     = 22'd0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  logic                   slot0_cs,
    input  logic                   slot1_cs,
    input  logic [`SLOT_AW-1:0]    slot0_addr,
    input  logic [`SLOT_AW-1:0]    slot1_addr,
    input  logic                   slot0_rnw,
    input  logic [15:0]            slot0_din,
    input  logic [1:0]             slot0_dsn,
    input  memmap_pkg::sdram_rsp_t rsp,
    input  logic [15:0]            data_read,
    output memmap_pkg::sdram_req_t req,
    output logic [15:0]            slot0_dout,
    output logic [15:0]            slot1_dout,
    output logic                   slot0_ok,
    output logic                   slot1_ok
);

    memmap_pkg::slot_state_e st [2];
    logic [`SLOT_AW-1:0]     addr_in [2];
    logic [`SLOT_AW-1:0]     saddr [2];    // Address of the last access
    logic [15:0]             sword [2];    // Last word read
    logic [1:0]              cs_in;
    logic [1:0]              rnw_in;
    logic [1:0]              srnw;         // Last access was a read
    logic [1:0]              cached;       // sword matches saddr
    logic [1:0]              ok;
    logic [1:0]              match;
    logic [1:0]              hit;
    logic [1:0]              held;
    logic [1:0]              settled;
    logic [1:0]              serve;
    logic [1:0]              want;
    logic [1:0]              issue;
    logic [1:0]              ack_in;
    logic [1:0]              fill;
    logic                    owner;        // Slot holding the bus
    logic                    busy;
    logic                    bus_free;
    logic                    req_rd;
    logic                    req_wr;
    logic [21:0]             req_addr;
    logic [15:0]             req_din;
    logic [1:0]              req_mask;

    assign cs_in      = {slot1_cs, slot0_cs};
    assign rnw_in     = {1'b1, SLOT0_WRITE ? slot0_rnw : 1'b1};
    assign addr_in[0] = slot0_addr;
    assign addr_in[1] = slot1_addr;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            match[i]   = addr_in[i] == saddr[i];
            hit[i]     = cached[i] && match[i] && rnw_in[i];
            // Finished write still held by the CPU
            held[i]    = st[i] == memmap_pkg::ST_VALID && match[i] && !srnw[i] && !rnw_in[i];
            settled[i] = st[i] == memmap_pkg::ST_IDLE || st[i] == memmap_pkg::ST_VALID;
            serve[i]   = cs_in[i] && settled[i] && (hit[i] || held[i]);
            want[i]    = cs_in[i] && settled[i] && !(hit[i] || held[i]);
            ack_in[i]  = rsp.ack && int'(owner) == i && st[i] == memmap_pkg::ST_WAIT_ACK;
            fill[i]    = rsp.rdy && int'(owner) == i && st[i] == memmap_pkg::ST_WAIT_DATA;
        end
    end

    assign busy     = !settled[0] || !settled[1];
    assign bus_free = !hold && !busy;
    assign issue[0] = want[0] && bus_free;
    assign issue[1] = want[1] && !want[0] && bus_free;   // Slot 0 first

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                st[i] <= memmap_pkg::ST_IDLE;
            end
            cached <= '0;
            ok     <= '0;
            owner  <= 1'b0;
            req_rd <= 1'b0;
            req_wr <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (issue[i]) begin
                    st[i]     <= memmap_pkg::ST_WAIT_ACK;
                    cached[i] <= 1'b0;   // Old word gone, writes included
                    ok[i]     <= 1'b0;
                end else if (serve[i]) begin
                    st[i] <= memmap_pkg::ST_VALID;
                    ok[i] <= 1'b1;
                end else if (ack_in[i]) begin
                    st[i] <= srnw[i] ? memmap_pkg::ST_WAIT_DATA : memmap_pkg::ST_VALID;
                    ok[i] <= !srnw[i] && cs_in[i] && match[i];   // Write ends here
                end else if (fill[i]) begin
                    st[i]     <= memmap_pkg::ST_VALID;
                    cached[i] <= 1'b1;
                    ok[i]     <= cs_in[i] && match[i];
                end else if (settled[i]) begin
                    st[i] <= memmap_pkg::ST_IDLE;   // Deselected or waiting its turn
                    ok[i] <= 1'b0;
                end
            end
            if (issue[0] || issue[1]) begin
                owner  <= issue[1];
                req_rd <= issue[0] ? rnw_in[0] : 1'b1;
                req_wr <= issue[0] && !rnw_in[0];
            end else if (ack_in[0] || ack_in[1]) begin
                req_rd <= 1'b0;
                req_wr <= 1'b0;
            end
        end
    end

    // Access payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (issue[i]) begin
                saddr[i] <= addr_in[i];
                srnw[i]  <= rnw_in[i];
            end
            if (fill[i]) begin
                sword[i] <= data_read;
            end
        end
        if (issue[0]) begin
            req_addr <= {{(22 - `SLOT_AW){1'b0}}, slot0_addr} + OFFSET0;
            req_din  <= slot0_din;
            req_mask <= slot0_dsn;
        end else if (issue[1]) begin
            req_addr <= {{(22 - `SLOT_AW){1'b0}}, slot1_addr} + OFFSET1;
        end
    end

    assign req = '{
        addr: req_addr,
        rd:   req_rd,
        wr:   req_wr,
        din:  req_din,
        mask: req_mask
    };

    assign slot0_dout = sword[0];
    assign slot1_dout = sword[1];
    assign slot0_ok   = ok[0];
    assign slot1_ok   = ok[1];

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(req.rd && req.wr)
    ) else $error("bank requested read and write together");

    // Controller data strobes only come back for an access in flight
    a_data_busy: assert property (
        @(posedge clk) disable iff (reset)
        (rsp.dst || rsp.rdy) |-> busy
    ) else $error("data strobe with the bank idle");

endmodule

// File: logic/rom_loader.sv
// Expects loader bytes in address order, no new byte while a write is pending, even image length
`timescale 1ns/1ns
`include "memmap_consts.svh"

module rom_loader (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  downloading,
    input  logic [`IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]            ioctl_dout,
    input  logic                  ioctl_wr,
    input  logic                  prog_ack,
    output memmap_pkg::prog_req_t prog,
    output logic [1:0]            game_id,
    output logic [1:0]            fd_en,
    output logic                  dwnld_busy
);

    logic [`IOCTL_AW-1:0] rom_addr;   // Byte address past the header
    logic [`IOCTL_AW-1:0] bank_addr;  // Byte address inside the target bank
    logic                 header;
    logic                 accept;
    logic                 in_ba1;
    logic [7:0]           low_byte;   // Even byte waiting for its pair
    logic                 prog_we;
    logic [`SDRAM_AW-1:0] prog_addr;
    logic [15:0]          prog_data;
    logic [1:0]           prog_ba;

    assign header    = ioctl_addr < `HEADER_LEN;
    assign accept    = downloading && ioctl_wr && !prog_we;
    assign rom_addr  = ioctl_addr - `HEADER_LEN;
    assign in_ba1    = rom_addr >= `BA1_START;
    assign bank_addr = in_ba1 ? rom_addr - `BA1_START : rom_addr;

    // Busy until the final word is in SDRAM
    assign dwnld_busy = downloading | prog_we;

    assign prog = '{
        addr: prog_addr,
        data: prog_data,
        mask: 2'b00,
        ba:   prog_ba,
        we:   prog_we
    };

    // Header decode and write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            fd_en   <= '0;
            game_id <= '0;
        end else begin
            if (prog_we && prog_ack) begin
                prog_we <= 1'b0;
            end
            if (accept && header) begin
                if (ioctl_addr[3:0] == 4'd0) begin
                    fd_en <= ioctl_dout[1:0];     // Decoder enables
                end
                if (ioctl_addr[3:0] == 4'd1) begin
                    game_id <= ioctl_dout[1:0];
                end
            end
            if (accept && !header && rom_addr[0]) begin
                prog_we <= 1'b1;                  // Odd byte completes a word
            end
        end
    end

    // Word assembly, little endian
    always_ff @(posedge clk) begin
        if (accept && !header) begin
            if (!rom_addr[0]) begin
                low_byte <= ioctl_dout;
            end else begin
                prog_data <= {ioctl_dout, low_byte};
                prog_addr <= bank_addr[`SDRAM_AW:1];
                prog_ba   <= in_ba1 ? 2'd1 : 2'd0;
            end
        end
    end

    // Strobe only drops after the controller took the word
    a_we_held: assert property (
        @(posedge clk) disable iff (reset)
        $fell(prog_we) |-> $past(prog_ack)
    ) else $error("programming strobe dropped without prog_ack");

    // Loader must wait for the pending write
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        prog_we |-> !(downloading && ioctl_wr)
    ) else $error("loader byte arrived while a write was pending");

endmodule

// File: logic/memmap_pkg.sv
// Types shared by the loader, the bank arbiters and the SDRAM model; 22-bit word addresses only
package memmap_pkg;

    // Slot access state
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,  // No access in flight
        ST_WAIT_ACK  = 2'd1,  // Strobe high, waiting for the controller
        ST_WAIT_DATA = 2'd2,  // Read accepted, data not back yet
        ST_VALID     = 2'd3   // Access finished for the stored address
    } slot_state_e;

    // Bank request towards the SDRAM controller, 42 bits
    typedef struct packed {
        logic [21:0] addr;    // Word address
        logic        rd;
        logic        wr;
        logic [15:0] din;     // Write data
        logic [1:0]  mask;    // Active low byte mask
    } sdram_req_t;

    // Controller strobes back to one bank
    // Read data comes on the shared data_read bus
    typedef struct packed {
        logic ack;            // Request taken
        logic dst;            // First data cycle
        logic rdy;            // data_read holds the word
    } sdram_rsp_t;

    // Programming write from the ROM download, 43 bits
    typedef struct packed {
        logic [21:0] addr;    // Word address inside the bank
        logic [15:0] data;
        logic [1:0]  mask;    // Active low, both bytes written during download
        logic [1:0]  ba;      // Target bank
        logic        we;      // Level, held until prog_ack
    } prog_req_t;

endpackage

// File: logic/memmap_consts.svh
// Map sized for a short simulation image; a full game image needs larger bank starts
`ifndef MEMMAP_CONSTS_SVH
`define MEMMAP_CONSTS_SVH

// Address widths
`define IOCTL_AW   25              // Loader byte address
`define SDRAM_AW   22              // Bank word address
`define SLOT_AW    18              // Slot word address

// Download layout in bytes
`define HEADER_LEN 25'd16          // Header bytes ahead of the ROM image

// ROM image byte addresses, counted after the header
`define BA1_START  25'h0_0040      // First graphics byte, start of bank 1
`define SND_START  25'h0_0060      // Sound ROM sits above graphics in bank 1

// Word offsets inside a bank
`define RAM_OFFSET 22'h00100       // Work RAM above program ROM in bank 0
`define SND_OFFSET 22'h00010       // Equals (SND_START - BA1_START) / 2

`endif
